// File: logic/credit_link_pkg.sv
// Shared sizes for the multi-lane credit-flow receiver
// Lane count, word width, credit depth and the widths derived from them

package credit_link_pkg;

  // --------------------------------------------------------------------
  // Base sizes
  // --------------------------------------------------------------------

  // Number of independent lanes on the link
  localparam int num_lanes = 4;

  // Width of one data word carried on any lane
  localparam int data_width = 16;

  // Buffer depth per lane, which is also the credit count after reset
  localparam int max_credit = 4;

  // --------------------------------------------------------------------
  // Derived widths
  // --------------------------------------------------------------------

  // Bits needed to name a lane
  localparam int lane_id_width = $clog2(num_lanes);

  // A credit count or a buffer occupancy runs from 0 up to max_credit inclusive
  localparam int count_width = $clog2(max_credit + 1);

  // Read and write pointers address max_credit slots
  localparam int ptr_width = (max_credit > 1) ? $clog2(max_credit) : 1;

endpackage : credit_link_pkg

// File: logic/lane_dispatch.sv
// Entry register for the push side of the link
// Decodes the registered lane number into one valid strobe per lane

`timescale 1ns/1ps

module lane_dispatch (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 push_valid,
  input  logic [credit_link_pkg::lane_id_width-1:0] push_lane,
  input  logic [credit_link_pkg::data_width-1:0]    push_data,
  output logic [credit_link_pkg::num_lanes-1:0]     lane_valid,
  output logic [credit_link_pkg::data_width-1:0]    lane_data
);

  import credit_link_pkg::*;

  // One-hot form of the incoming push, before the entry register
  logic [num_lanes-1:0] push_onehot;

  // --------------------------------------------------------------------
  // Lane decode
  // --------------------------------------------------------------------

  // Only the addressed lane sees a strobe, and only when a word is offered
  always_comb begin
    push_onehot = '0;
    if (push_valid) begin
      push_onehot[push_lane] = 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Entry register
  // --------------------------------------------------------------------

  // The link may be long, so the strobes are retimed once on entry
  // The sender only pushes against a held credit, so there is no back-pressure here
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lane_valid <= '0;
    end else begin
      lane_valid <= push_onehot;
    end
  end

  // Data is shared by all lanes and only captured with a valid push
  // The lane buffer ignores it unless its own strobe is set
  always_ff @(posedge clk) begin
    if (push_valid) begin
      lane_data <= push_data;
    end
  end

endmodule : lane_dispatch

// File: logic/credit_receiver.sv
// Per-lane credit receiver
// Counts unreleased credits and passes push data straight to the lane buffer

`timescale 1ns/1ps

module credit_receiver (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   push_credit_stall,
  output logic                                   push_credit,
  input  logic                                   push_valid,
  input  logic [credit_link_pkg::data_width-1:0]  push_data,
  input  logic                                   pop_credit,
  output logic                                   pop_valid,
  output logic [credit_link_pkg::data_width-1:0]  pop_data,
  output logic [credit_link_pkg::count_width-1:0] credit_count
);

  import credit_link_pkg::*;

  // Set from the first cycle after reset, so no credit leaves while in reset
  logic release_en;

  // --------------------------------------------------------------------
  // Credit release
  // --------------------------------------------------------------------

  // A credit goes out whenever the sender is not stalling this lane and
  // either a credit is held here or one is coming back from the buffer
  // The returning credit can pass straight through when the count is zero
  assign push_credit = release_en && !push_credit_stall &&
                       ((credit_count != '0) || pop_credit);

  // --------------------------------------------------------------------
  // Credit counter
  // --------------------------------------------------------------------

  // Reset loads one credit per buffer slot
  // A return adds one and a release takes one, both in the same cycle cancel
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit_count <= count_width'(max_credit);
      release_en   <= 1'b0;
    end else begin
      release_en <= 1'b1;
      case ({pop_credit, push_credit})
        2'b10:   credit_count <= credit_count + 1'b1;
        2'b01:   credit_count <= credit_count - 1'b1;
        default: credit_count <= credit_count;
      endcase
    end
  end

  // --------------------------------------------------------------------
  // Data path
  // --------------------------------------------------------------------

  // No storage on this path, the lane buffer holds every word
  // Valid and data reach the buffer in the same cycle they arrive
  assign pop_valid = push_valid;
  assign pop_data  = push_data;

endmodule : credit_receiver

// File: logic/lane_buffer.sv
// Per-lane circular FIFO sized to the lane's credit depth
// Each word drained returns one credit to the lane's receiver

`timescale 1ns/1ps

module lane_buffer (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  wr_valid,
  input  logic [credit_link_pkg::data_width-1:0] wr_data,
  input  logic                                  rd_pop,
  output logic                                  not_empty,
  output logic [credit_link_pkg::data_width-1:0] head_data,
  output logic                                  pop_credit
);

  import credit_link_pkg::*;

  // Storage, one slot per credit
  logic [data_width-1:0] mem [max_credit];

  // Pointers into the storage
  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;

  // Number of words held, 0 up to max_credit
  logic [count_width-1:0] fill_count;

  // A pop only counts when there is a word to take
  logic pop_take;

  // --------------------------------------------------------------------
  // Status and read side
  // --------------------------------------------------------------------

  assign not_empty  = (fill_count != '0);
  assign head_data  = mem[rd_ptr];
  assign pop_take   = rd_pop && not_empty;

  // Every word that leaves frees a slot, which goes back as a credit
  assign pop_credit = pop_take;

  // --------------------------------------------------------------------
  // Storage write
  // --------------------------------------------------------------------

  // The sender holds a credit for every write, so a full buffer is never written
  always_ff @(posedge clk) begin
    if (wr_valid) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // --------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------

  // Pointers wrap at the last slot, so the depth need not be a power of two
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill_count <= '0;
    end else begin
      if (wr_valid) begin
        wr_ptr <= (wr_ptr == ptr_width'(max_credit - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_take) begin
        rd_ptr <= (rd_ptr == ptr_width'(max_credit - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // A write and a pop in the same cycle leave the occupancy unchanged
      case ({wr_valid, pop_take})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: fill_count <= fill_count;
      endcase
    end
  end

endmodule : lane_buffer

// File: logic/lane_arbiter.sv
// Round-robin drain arbiter over the lane buffers
// Merges the head words into one output stream under out_ready back-pressure

`timescale 1ns/1ps

module lane_arbiter (
  input  logic                                                 clk,
  input  logic                                                 rst_n,
  input  logic [credit_link_pkg::num_lanes-1:0]                 lane_not_empty,
  input  logic [credit_link_pkg::num_lanes*credit_link_pkg::data_width-1:0] lane_head,
  output logic [credit_link_pkg::num_lanes-1:0]                 lane_pop,
  output logic                                                 out_valid,
  output logic [credit_link_pkg::data_width-1:0]                out_data,
  output logic [credit_link_pkg::lane_id_width-1:0]             out_lane,
  input  logic                                                 out_ready
);

  import credit_link_pkg::*;

  // Lane granted in the last taken cycle
  logic [lane_id_width-1:0] last_grant;

  // Grant kept across a stalled cycle so the output stays stable
  logic                     hold_valid;
  logic [lane_id_width-1:0] hold_lane;

  // Result of the round-robin search
  logic                     search_valid;
  logic [lane_id_width-1:0] search_lane;

  // Lane currently presented on the output
  logic [lane_id_width-1:0] grant_lane;

  // The presented word is taken this cycle
  logic take;

  // --------------------------------------------------------------------
  // Round-robin search
  // --------------------------------------------------------------------

  // Start just after the last granted lane and wrap around once
  always_comb begin : rr_search
    logic [lane_id_width-1:0] idx;
    search_valid = 1'b0;
    search_lane  = last_grant;
    for (int i = 1; i <= num_lanes; i++) begin
      idx = lane_id_width'((int'(last_grant) + i) % num_lanes);
      if (!search_valid && lane_not_empty[idx]) begin
        search_valid = 1'b1;
        search_lane  = idx;
      end
    end
  end

  // --------------------------------------------------------------------
  // Output and pop
  // --------------------------------------------------------------------

  // A held grant wins over a fresh search, since a lane that became
  // non-empty while stalled must not displace the word already shown
  assign grant_lane = hold_valid ? hold_lane : search_lane;
  assign out_valid  = hold_valid || search_valid;
  assign out_lane   = grant_lane;
  assign out_data   = lane_head[grant_lane*data_width +: data_width];
  assign take       = out_valid && out_ready;

  // Only the granted lane pops, and only when the word is taken
  always_comb begin
    lane_pop = '0;
    if (take) begin
      lane_pop[grant_lane] = 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Pointer and hold state
  // --------------------------------------------------------------------

  // Reset to the top lane so that lane 0 is served first
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_grant <= lane_id_width'(num_lanes - 1);
      hold_valid <= 1'b0;
      hold_lane  <= '0;
    end else begin
      if (take) begin
        last_grant <= grant_lane;
      end
      hold_valid <= out_valid && !out_ready;
      hold_lane  <= grant_lane;
    end
  end

endmodule : lane_arbiter

// File: logic/credit_link_rx.sv
// Top level of the multi-lane credit-flow receiver
// Entry dispatcher, one credit receiver and buffer per lane, and the drain arbiter

`timescale 1ns/1ps

module credit_link_rx (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      push_valid,
  input  logic [credit_link_pkg::lane_id_width-1:0] push_lane,
  input  logic [credit_link_pkg::data_width-1:0]    push_data,
  input  logic [credit_link_pkg::num_lanes-1:0]     push_credit_stall,
  output logic [credit_link_pkg::num_lanes-1:0]     push_credit,
  output logic                                      out_valid,
  output logic [credit_link_pkg::data_width-1:0]    out_data,
  output logic [credit_link_pkg::lane_id_width-1:0] out_lane,
  input  logic                                      out_ready
);

  import credit_link_pkg::*;

  // Registered push strobes and the shared word
  logic [num_lanes-1:0]  lane_valid;
  logic [data_width-1:0] lane_data;

  // Receiver to buffer write path, per lane
  logic [num_lanes-1:0]  buf_wr_valid;
  logic [data_width-1:0] buf_wr_data [num_lanes];

  // Credit returns and unreleased credit counts, per lane
  logic [num_lanes-1:0]   lane_pop_credit;
  logic [count_width-1:0] lane_credit_count [num_lanes];

  // Buffer to arbiter
  logic [num_lanes-1:0]            lane_not_empty;
  logic [num_lanes*data_width-1:0] lane_head;
  logic [num_lanes-1:0]            lane_pop;

  // --------------------------------------------------------------------
  // Push entry
  // --------------------------------------------------------------------

  lane_dispatch i_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_lane  (push_lane),
    .push_data  (push_data),
    .lane_valid (lane_valid),
    .lane_data  (lane_data)
  );

  // --------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    // Credits for this lane go out here and come back from its buffer
    credit_receiver i_receiver (
      .clk               (clk),
      .rst_n             (rst_n),
      .push_credit_stall (push_credit_stall[i]),
      .push_credit       (push_credit[i]),
      .push_valid        (lane_valid[i]),
      .push_data         (lane_data),
      .pop_credit        (lane_pop_credit[i]),
      .pop_valid         (buf_wr_valid[i]),
      .pop_data          (buf_wr_data[i]),
      .credit_count      (lane_credit_count[i])
    );

    lane_buffer i_buffer (
      .clk        (clk),
      .rst_n      (rst_n),
      .wr_valid   (buf_wr_valid[i]),
      .wr_data    (buf_wr_data[i]),
      .rd_pop     (lane_pop[i]),
      .not_empty  (lane_not_empty[i]),
      .head_data  (lane_head[i*data_width +: data_width]),
      .pop_credit (lane_pop_credit[i])
    );
  end

  // --------------------------------------------------------------------
  // Drain
  // --------------------------------------------------------------------

  lane_arbiter i_arbiter (
    .clk            (clk),
    .rst_n          (rst_n),
    .lane_not_empty (lane_not_empty),
    .lane_head      (lane_head),
    .lane_pop       (lane_pop),
    .out_valid      (out_valid),
    .out_data       (out_data),
    .out_lane       (out_lane),
    .out_ready      (out_ready)
  );

endmodule : credit_link_rx

// File: sim/credit_link_rx_assert.sv
// Concurrent assertions for the credit-flow receiver bound to its top level
// Credit conservation, stall behaviour, buffer overflow, single pop and output hold

`timescale 1ns/1ps

module credit_link_rx_assert (
  input logic                                      clk,
  input logic                                      rst_n,
  input logic [credit_link_pkg::num_lanes-1:0]     push_credit_stall,
  input logic [credit_link_pkg::num_lanes-1:0]     push_credit,
  input logic [credit_link_pkg::num_lanes-1:0]     buf_wr_valid,
  input logic [credit_link_pkg::count_width-1:0]   lane_credit_count [credit_link_pkg::num_lanes],
  input logic [credit_link_pkg::num_lanes-1:0]     lane_pop,
  input logic [credit_link_pkg::num_lanes-1:0]     lane_not_empty,
  input logic                                      out_valid,
  input logic [credit_link_pkg::data_width-1:0]    out_data,
  input logic [credit_link_pkg::lane_id_width-1:0] out_lane,
  input logic                                      out_ready
);

  import credit_link_pkg::*;

  // Occupancy per lane rebuilt from the write strobes and real pops
  logic [count_width-1:0] occ [num_lanes];

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_lanes; i++) begin
      if (!rst_n) occ[i] <= '0;
      else occ[i] <= occ[i] + count_width'(buf_wr_valid[i])
                     - count_width'(lane_pop[i] && lane_not_empty[i]);
    end
  end

  // --------------------------------------------------------------------
  // Per-lane properties
  // --------------------------------------------------------------------

  for (genvar i = 0; i < num_lanes; i++) begin : g_lane_check
    assert property (@(posedge clk) disable iff (!rst_n)
                     push_credit[i] |-> !push_credit_stall[i])
      else $error("push_credit raised on stalled lane %0d", i);
    assert property (@(posedge clk) disable iff (!rst_n)
                     buf_wr_valid[i] |-> (occ[i] < count_width'(max_credit)))
      else $error("lane buffer %0d written while full", i);
    // Credits still held, words on the way in and words stored never exceed the slots
    assert property (@(posedge clk) disable iff (!rst_n)
                     (int'(lane_credit_count[i]) + int'(buf_wr_valid[i]) + int'(occ[i])
                      <= max_credit))
      else $error("lane %0d accounts for more credits than buffer slots", i);
  end

  // --------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------

  assert property (@(posedge clk) disable iff (!rst_n) $onehot0(lane_pop))
    else $error("more than one lane popped at once");

  // A word offered and not taken stays exactly as it was
  assert property (@(posedge clk) disable iff (!rst_n)
                   (out_valid && !out_ready) |=>
                   (out_valid && $stable(out_data) && $stable(out_lane)))
    else $error("output changed while stalled by out_ready");

endmodule : credit_link_rx_assert

// File: sim/tb_credit_link_rx.sv
// Testbench for the multi-lane credit-flow receiver
// Table-driven sender model, per-lane scoreboards and output monitor

`timescale 1ns/1ps

module tb_credit_link_rx;

  import credit_link_pkg::*;

  // Rows 0..15 fill every lane with out_ready low, 16..23 stall lane 2,
  // 24..31 release it, and the rest run with random back-pressure
  localparam int table_len      = 48;
  localparam int low_rows       = 16;
  localparam int stall_end      = 24;
  localparam int random_start   = 32;
  localparam int timeout_cycles = 20 * table_len + 200;

  logic                     clk = 1'b0;
  logic                     rst_n;
  logic                     push_valid;
  logic [lane_id_width-1:0] push_lane;
  logic [data_width-1:0]    push_data;
  logic [num_lanes-1:0]     push_credit_stall;
  logic [num_lanes-1:0]     push_credit;
  logic                     out_valid;
  logic [data_width-1:0]    out_data;
  logic [lane_id_width-1:0] out_lane;
  logic                     out_ready;

  // Stimulus table where ready mode 2 means a random level every cycle
  logic [lane_id_width-1:0] row_lane  [table_len];
  logic [data_width-1:0]    row_data  [table_len];
  logic [num_lanes-1:0]     row_stall [table_len];
  int                       row_ready [table_len];

  // Sender model and scoreboards
  int                    sender_credit [num_lanes];
  int                    total_credit  [num_lanes];
  int                    pushed        [num_lanes];
  int                    drained       [num_lanes];
  logic [data_width-1:0] exp_q         [num_lanes][$];

  int                    mismatch_count = 0;
  int                    other_count    = 0;
  int                    taken_count    = 0;
  int                    cycle_count    = 0;
  logic [31:0]           lfsr_state     = 32'h2969;
  logic                  hold_seen      = 1'b0;
  logic [data_width-1:0] prev_data;
  logic [lane_id_width-1:0] prev_lane;

  always #20 clk = ~clk;

  credit_link_rx i_dut (.*);

  bind credit_link_rx credit_link_rx_assert i_assert (.*);

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  // Taps 32, 22, 2 and 1 with one step per bit taken
  function automatic logic next_random_bit();
    logic feedback;
    feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], feedback};
    return feedback;
  endfunction

  function automatic logic ready_level(input int mode);
    return (mode == 2) ? next_random_bit() : (mode == 1);
  endfunction

  function automatic int words_pending();
    int sum;
    sum = 0;
    for (int l = 0; l < num_lanes; l++) sum += exp_q[l].size();
    return sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      mismatch_count++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic finish_run();
    $display("Errors: %0d value mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  endtask

  // Data words carry their lane in the top bits and the row in the rest
  task automatic build_table();
    logic [lane_id_width-1:0] lane;
    for (int r = 0; r < table_len; r++) begin
      if (r < low_rows) lane = lane_id_width'(r % num_lanes);
      else if (r < stall_end) lane = (r % 3 == 2) ? 2'd3 : lane_id_width'(r % 3);
      else if (r < random_start) lane = lane_id_width'(r % num_lanes);
      else for (int b = 0; b < lane_id_width; b++) lane[b] = next_random_bit();
      row_lane[r]  = lane;
      row_data[r]  = {lane, (data_width - lane_id_width)'(r)};
      row_stall[r] = (r >= low_rows && r < stall_end) ? 4'b0100 : 4'b0000;
      row_ready[r] = (r < low_rows) ? 0 : ((r < random_start) ? 1 : 2);
    end
  endtask

  // ----------------------------------------------------------------------
  // Output and credit monitor sampled mid-cycle where everything is settled
  // ----------------------------------------------------------------------

  task automatic take_word();
    logic [data_width-1:0] expected;
    if (exp_q[out_lane].size() == 0) begin
      $display("Output word 0x%h on lane %0d with no word pending", out_data, out_lane);
      other_count++;
    end else begin
      expected = exp_q[out_lane].pop_front();
      check_value("out_data", out_data, expected);
      drained[out_lane]++;
    end
    // All lanes start full, so the first words rotate from lane 0
    if (taken_count < num_lanes * max_credit) begin
      check_value("out_lane", out_lane, taken_count % num_lanes);
    end
    taken_count++;
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      check_value("push_credit", push_credit, '0);
      check_value("out_valid", out_valid, 1'b0);
    end else begin
      for (int l = 0; l < num_lanes; l++) begin
        if (push_credit[l]) begin
          if (push_credit_stall[l]) begin
            $display("Credit released on stalled lane %0d", l);
            other_count++;
          end
          sender_credit[l]++;
          total_credit[l]++;
          if (sender_credit[l] > max_credit) begin
            $display("Sender holds more than %0d credits on lane %0d", max_credit, l);
            other_count++;
          end
        end
      end
      if (!$onehot0(i_dut.lane_pop)) begin
        $display("More than one lane popped in the same cycle");
        other_count++;
      end
      // A word not taken last cycle must still be offered unchanged
      if (hold_seen) begin
        check_value("out_valid", out_valid, 1'b1);
        check_value("out_data", out_data, prev_data);
        check_value("out_lane", out_lane, prev_lane);
      end
      if (out_valid && out_ready) take_word();
      hold_seen = out_valid && !out_ready;
      prev_data = out_data;
      prev_lane = out_lane;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("Timeout: run did not complete within %0d cycles", timeout_cycles);
      other_count++;
      finish_run();
    end
  end

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------

  initial begin
    rst_n             = 1'b0;
    push_valid        = 1'b0;
    push_lane         = '0;
    push_data         = '0;
    push_credit_stall = '0;
    out_ready         = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Each lane hands out exactly its buffer depth and then goes quiet
    repeat (max_credit + 4) next_cycle();
    for (int l = 0; l < num_lanes; l++) begin
      check_value("push_credit total", total_credit[l], max_credit);
    end

    for (int r = 0; r < table_len; r++) begin
      if (r == low_rows) begin
        // With out_ready low the sender has spent every credit and waits
        push_valid = 1'b0;
        repeat (4) next_cycle();
        for (int l = 0; l < num_lanes; l++) check_value("sender credit", sender_credit[l], 0);
        check_value("out_valid", out_valid, 1'b1);
        // Lane 0 was filled first and is the first one served
        check_value("out_lane", out_lane, 0);
      end
      push_credit_stall = row_stall[r];
      out_ready         = ready_level(row_ready[r]);
      while (sender_credit[row_lane[r]] == 0) begin
        push_valid = 1'b0;
        next_cycle();
        out_ready = ready_level(row_ready[r]);
      end
      push_valid = 1'b1;
      push_lane  = row_lane[r];
      push_data  = row_data[r];
      sender_credit[row_lane[r]]--;
      pushed[row_lane[r]]++;
      exp_q[row_lane[r]].push_back(row_data[r]);
      next_cycle();
    end

    // Drain everything, then every drained word must have come back as a credit
    push_valid        = 1'b0;
    push_credit_stall = '0;
    out_ready         = 1'b1;
    while (words_pending() != 0) next_cycle();
    repeat (max_credit + 2) next_cycle();
    for (int l = 0; l < num_lanes; l++) begin
      check_value("drained words", drained[l], pushed[l]);
      check_value("push_credit total", total_credit[l], max_credit + drained[l]);
    end
    finish_run();
  end

endmodule : tb_credit_link_rx

// File: verilog.f
logic/credit_link_pkg.sv
logic/lane_dispatch.sv
logic/credit_receiver.sv
logic/lane_buffer.sv
logic/lane_arbiter.sv
logic/credit_link_rx.sv
sim/credit_link_rx_assert.sv
sim/tb_credit_link_rx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the credit-flow receiver testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_credit_link_rx -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_credit_link_rx +verilator+error+limit+100 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$log"; then
  echo "Result: pass"
  exit 0
else
  echo "Result: fail"
  exit 1
fi
